// ==== list.f ====
+incdir+dv
src/rx_pkg.sv
src/rx_frame_if.sv
src/rx_ctrl.sv
src/rx_crc_check.sv
src/rx_delay_line.sv
src/rx_out_gate.sv
src/rx_top.sv
dv/tb_rx_top.sv

// ==== Bender.yml ====
package:
  name: rx_datapath

sources:
  - files:
      - src/rx_pkg.sv
      - src/rx_frame_if.sv
      - src/rx_ctrl.sv
      - src/rx_crc_check.sv
      - src/rx_delay_line.sv
      - src/rx_out_gate.sv
      - src/rx_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_rx_top.sv

// ==== dv/rx_tests.svh ====
// Directed tests and frame helpers for the receive datapath testbench

   // Builds one frame with its CRC and drives its eight words
   task automatic send_frame(input bit rdy, input logic [5:0] valids,
                             input bit bad_faw, input bit bad_crc);
      logic [63:0] words [FRAME_WORDS];
      logic [31:0] crc;
      crc      = 32'hFFFF_FFFF;
      words[0] = {bad_faw ? ~FAW_PATTERN : FAW_PATTERN, 7'd0, rdy};
      for (int i = 1; i <= PAYLOAD_WORDS; i++) begin
         words[i] = {$urandom(), $urandom()};
         crc      = crc32_step(crc, words[i]);
      end
      words[7] = {crc ^ {31'd0, bad_crc}, 26'd0, valids};
      for (int i = 0; i < FRAME_WORDS; i++) begin
         step(1'b1, words[i]);
      end
   endtask

   // Next word of a well-formed frame at the current frame position
   task automatic fill_cycle();
      logic [63:0] word;
      if (pos == 0) begin
         word = {FAW_PATTERN, 7'd0, 1'b1};
      end else if (pos < FRAME_WORDS - 1) begin
         word = {$urandom(), $urandom()};
      end else begin
         word = {acc, 26'd0, 6'h3F};
      end
      step(1'b1, word);
   endtask

   task automatic fill_to_boundary();
      while (pos != 0) begin
         fill_cycle();
      end
   endtask

   task automatic restart();
      step(1'b0, '0);
      step(1'b0, '0);
   endtask

   // Keeps framing running until the chosen error flag is high
   task automatic wait_flag(input bit sel_crc, input int max_cycles, output int seen);
      int n;
      n = 0;
      while ((sel_crc ? crc_error_o : faw_error_o) !== 1'b1) begin
         if (n == max_cycles) begin
            report_timeout(sel_crc ? "crc_error_o" : "faw_error_o");
         end
         fill_cycle();
         n++;
      end
      seen = cyc - 1;
   endtask

   task automatic run_good_frames();
      logic [5:0]  valids [6];
      int unsigned r;
      int          expect_cnt;
      int          start_seen;
      r          = $urandom();
      valids[0]  = 6'b101101;
      valids[1]  = 6'h3F;
      valids[2]  = 6'h00;
      valids[3]  = r[5:0];
      valids[4]  = 6'b010010;
      valids[5]  = r[11:6];
      expect_cnt = 0;
      start_seen = valid_seen;
      for (int f = 0; f < 6; f++) begin
         send_frame(f[0], valids[f], 1'b0, 1'b0);
         for (int i = 0; i < PAYLOAD_WORDS; i++) begin
            expect_cnt += valids[f][i];
         end
      end
      // Trailing empty frames let the last payload drain
      send_frame(1'b0, 6'h00, 1'b0, 1'b0);
      send_frame(1'b0, 6'h00, 1'b0, 1'b0);
      check_value(valid_seen - start_seen, expect_cnt, "released word count");
   endtask

   task automatic test_good_frames();
      restart();
      run_good_frames();
   endtask

   task automatic test_bad_crc();
      int t0;
      int seen;
      int vs;
      restart();
      send_frame(1'b1, 6'h3F, 1'b0, 1'b0);
      t0 = cyc;
      send_frame(1'b1, 6'h3F, 1'b0, 1'b1);
      wait_flag(1'b1, 20, seen);
      // crc_done comes 9 cycles after the first payload word and the flag one cycle later
      check_value(seen, t0 + 1 + 10, "crc_error_o rise cycle");
      fill_to_boundary();
      vs = valid_seen;
      repeat (3) send_frame(1'b1, 6'h3F, 1'b0, 1'b0);
      check_value(valid_seen, vs, "tvalid_o count after CRC error");
      check_value(crc_error_o, 1'b1, "crc_error_o held");
   endtask

   task automatic test_bad_faw();
      int t0;
      int seen;
      int vs;
      restart();
      send_frame(1'b1, 6'h3F, 1'b0, 1'b0);
      t0 = cyc;
      step(1'b1, {~FAW_PATTERN, 7'd0, 1'b1});
      wait_flag(1'b0, 20, seen);
      check_value(seen, t0 + 1, "faw_error_o rise cycle");
      fill_to_boundary();
      vs = valid_seen;
      repeat (3) send_frame(1'b1, 6'h3F, 1'b0, 1'b0);
      check_value(valid_seen, vs, "tvalid_o count after FAW error");
      check_value(faw_error_o, 1'b1, "faw_error_o held");
   endtask

   task automatic test_rdy_toggle();
      logic [5:0] rdy_bits;
      rdy_bits = 6'b010110;
      restart();
      for (int k = 0; k < 6; k++) begin
         send_frame(rdy_bits[k], 6'h15, 1'b0, 1'b0);
         check_value(remote_rx_rdy_o, rdy_bits[k], "remote_rx_rdy_o");
      end
   endtask

   task automatic test_enable_drop();
      int t0;
      int seen;
      restart();
      t0 = cyc;
      send_frame(1'b1, 6'h3F, 1'b0, 1'b1);
      wait_flag(1'b1, 20, seen);
      check_value(seen, t0 + 1 + 10, "crc_error_o rise cycle before disable");
      fill_to_boundary();
      send_frame(1'b0, 6'h3F, 1'b1, 1'b0);
      check_value(faw_error_o, 1'b1, "faw_error_o before disable");
      check_value(crc_error_o, 1'b1, "crc_error_o before disable");
      step(1'b0, '0);
      step(1'b0, '0);
      check_value(tvalid_o, 1'b0, "tvalid_o after disable");
      check_value(faw_error_o, 1'b0, "faw_error_o after disable");
      check_value(crc_error_o, 1'b0, "crc_error_o after disable");
      check_value(remote_rx_rdy_o, 1'b0, "remote_rx_rdy_o after disable");
      run_good_frames();
   endtask

// ==== dv/tb_rx_top.sv ====
// Testbench for the receive datapath
// Drives framed words and checks every output each cycle against a reference model
`timescale 1ns/1ns

module tb_rx_top import rx_pkg::*; ();

   localparam int DATA_LAT     = 11;
   localparam int CRC_LAT      = 3;
   localparam int MODEL_CYCLES = 1024;

   logic        clk_i;
   logic        rst_n_i;
   logic        enable_i;
   logic [63:0] tdata_i;
   logic [63:0] tdata_o;
   logic        tvalid_o;
   logic        faw_error_o;
   logic        crc_error_o;
   logic        remote_rx_rdy_o;

   // Reference model arrays indexed by cycle number
   logic [63:0] exp_data [MODEL_CYCLES];
   bit          exp_slot [MODEL_CYCLES];
   bit          crc_event [MODEL_CYCLES];
   int          cyc;
   int          pos;
   logic [31:0] acc;
   bit          m_faw_err;
   bit          m_crc_err;
   bit          m_rdy;
   bit          m_run;
   int          valid_seen;
   int          seed;

   always #10 clk_i = ~clk_i;

   rx_top #(
      .DATA_LATENCY (DATA_LAT),
      .CRC_LATENCY  (CRC_LAT)
   ) dut_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .enable_i        (enable_i),
      .tdata_i         (tdata_i),
      .tdata_o         (tdata_o),
      .tvalid_o        (tvalid_o),
      .faw_error_o     (faw_error_o),
      .crc_error_o     (crc_error_o),
      .remote_rx_rdy_o (remote_rx_rdy_o)
   );

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         $display("Simulation failed");
         $fatal(1, "stopping at first error");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timed out at %0t ns waiting for %s", $time, what);
      $display("Simulation failed");
      $fatal(1, "wait limit reached");
   endtask

   // Checks the outputs of one cycle and drives the next word
   task automatic step(input logic en, input logic [63:0] word);
      @(negedge clk_i);
      if (cyc + 2 * FRAME_WORDS + DATA_LAT >= MODEL_CYCLES) begin
         $display("reference model ran out of cycles at %0t ns", $time);
         $display("Simulation failed");
         $fatal(1, "model arrays too small");
      end
      check_value(tdata_o, exp_data[cyc], "tdata_o");
      check_value(tvalid_o, exp_slot[cyc] && m_run, "tvalid_o");
      check_value(faw_error_o, m_faw_err, "faw_error_o");
      check_value(crc_error_o, m_crc_err, "crc_error_o");
      check_value(remote_rx_rdy_o, m_rdy, "remote_rx_rdy_o");
      if (tvalid_o) begin
         valid_seen++;
      end
      enable_i = en;
      tdata_i  = word;
      exp_data[cyc + DATA_LAT] = word;
      if (!en) begin
         // Disable flushes pending checks and clears every flag
         for (int i = 1; i <= 2 * FRAME_WORDS; i++) begin
            exp_slot[cyc + i]  = 1'b0;
            crc_event[cyc + i] = 1'b0;
         end
         pos       = 0;
         m_faw_err = 1'b0;
         m_crc_err = 1'b0;
         m_rdy     = 1'b0;
         m_run     = 1'b0;
      end else begin
         if (pos == 0) begin
            acc = 32'hFFFF_FFFF;
            if (word[63:8] != FAW_PATTERN) begin
               m_faw_err = 1'b1;
            end else begin
               m_rdy = word[0];
            end
         end else if (pos < FRAME_WORDS - 1) begin
            acc = crc32_step(acc, word);
         end else begin
            if (word[63:32] != acc) begin
               crc_event[cyc + CRC_LAT + 1] = 1'b1;
            end
            // Payload word i+1 leaves DATA_LAT cycles after it entered
            for (int i = 0; i < PAYLOAD_WORDS; i++) begin
               exp_slot[cyc - PAYLOAD_WORDS + DATA_LAT + i] = word[i];
            end
         end
         pos = (pos + 1) % FRAME_WORDS;
         if (crc_event[cyc + 1]) begin
            m_crc_err = 1'b1;
         end
         m_run = !m_faw_err && !m_crc_err;
      end
      cyc++;
   endtask

   `include "rx_tests.svh"

   initial begin
      clk_i      = 1'b0;
      rst_n_i    = 1'b0;
      enable_i   = 1'b0;
      tdata_i    = '0;
      cyc        = 0;
      pos        = 0;
      acc        = 32'hFFFF_FFFF;
      m_faw_err  = 1'b0;
      m_crc_err  = 1'b0;
      m_rdy      = 1'b0;
      m_run      = 1'b0;
      valid_seen = 0;
      seed       = 32'h7af3;
      void'($urandom(seed));
      for (int i = 0; i < MODEL_CYCLES; i++) begin
         exp_data[i] = '0;
      end
      repeat (4) @(negedge clk_i);
      rst_n_i = 1'b1;
      test_good_frames();
      test_bad_crc();
      test_bad_faw();
      test_rdy_toggle();
      test_enable_drop();
      $display("Simulation passed");
      $finish;
   end

endmodule

// ==== src/rx_top.sv ====
// Receive datapath top level: frame control, CRC check, data delay
// and tvalid gating for 8-word frames from the deserializer
`timescale 1ns/1ns

module rx_top #(
   parameter int DATA_LATENCY = 11,
   parameter int CRC_LATENCY  = 3
) (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        enable_i,
   input  logic [63:0] tdata_i,
   output logic [63:0] tdata_o,
   output logic        tvalid_o,
   output logic        faw_error_o,
   output logic        crc_error_o,
   output logic        remote_rx_rdy_o
);

   logic crc_done;
   logic crc_bad;
   logic release_ok;

   rx_frame_if frame_if ();

   rx_ctrl u_ctrl (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .enable_i        (enable_i),
      .tdata_i         (tdata_i),
      .frame           (frame_if.framer),
      .crc_done_i      (crc_done),
      .crc_bad_i       (crc_bad),
      .release_ok_o    (release_ok),
      .faw_error_o     (faw_error_o),
      .crc_error_o     (crc_error_o),
      .remote_rx_rdy_o (remote_rx_rdy_o)
   );

   rx_crc_check #(
      .CRC_LATENCY (CRC_LATENCY)
   ) u_crc_check (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .frame      (frame_if.sink),
      .crc_done_o (crc_done),
      .crc_bad_o  (crc_bad)
   );

   rx_delay_line #(
      .DATA_LATENCY (DATA_LATENCY)
   ) u_delay_line (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .frame   (frame_if.sink),
      .tdata_o (tdata_o)
   );

   rx_out_gate u_out_gate (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .frame        (frame_if.sink),
      .crc_done_i   (crc_done),
      .release_ok_i (release_ok),
      .tvalid_o     (tvalid_o)
   );

endmodule

// ==== src/rx_out_gate.sv ====
// Output gate: holds the valid bits of a checked frame and steps
// them out as tvalid across the six payload slots
`timescale 1ns/1ns

module rx_out_gate import rx_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   rx_frame_if.sink frame,
   input  logic     crc_done_i,
   input  logic     release_ok_i,
   output logic     tvalid_o
);

   rx_vd_pkt_t               vd_pkt;
   logic [PAYLOAD_WORDS-1:0] valids_q;
   logic [PAYLOAD_WORDS-1:0] release_q;
   logic [PAYLOAD_WORDS-1:0] shift_q;
   logic                     start_q;

   assign vd_pkt = rx_vd_pkt_t'(frame.word);

   // Valid bits wait here while the CRC compare runs
   always_ff @(posedge clk_i) begin
      if (frame.crc_boundary) begin
         valids_q <= vd_pkt.valids;
      end
      if (crc_done_i) begin
         release_q <= valids_q;
      end
   end

   // Shifting starts two cycles after crc_done, then empties to zero
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !frame.active) begin
         start_q <= 1'b0;
         shift_q <= '0;
      end else begin
         start_q <= crc_done_i;
         if (start_q) begin
            shift_q <= release_q;
         end else begin
            shift_q <= shift_q >> 1;
         end
      end
   end

   // Empty slots cover the FAW and packet words
   assign tvalid_o = release_ok_i && shift_q[0];

endmodule

// ==== src/rx_delay_line.sv ====
// Fixed-depth delay line aligning the received words with the
// tvalid decisions made after the CRC check
`timescale 1ns/1ns

module rx_delay_line #(
   parameter int DATA_LATENCY = 11
) (
   input  logic        clk_i,
   input  logic        rst_n_i,
   rx_frame_if.sink    frame,
   output logic [63:0] tdata_o
);

   logic [63:0] dly_q [DATA_LATENCY];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < DATA_LATENCY; i++) begin
            dly_q[i] <= '0;
         end
      end else begin
         dly_q[0] <= frame.word;
         for (int i = 1; i < DATA_LATENCY; i++) begin
            dly_q[i] <= dly_q[i-1];
         end
      end
   end

   assign tdata_o = dly_q[DATA_LATENCY-1];

endmodule

// ==== src/rx_crc_check.sv ====
// CRC checker: accumulates CRC-32 over the payload words of each frame
// and compares it to the validation packet through a short pipeline
`timescale 1ns/1ns

module rx_crc_check import rx_pkg::*; #(
   parameter int CRC_LATENCY = 3
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   rx_frame_if.sink frame,
   output logic     crc_done_o,
   output logic     crc_bad_o
);

   rx_vd_pkt_t  vd_pkt;
   logic [31:0] crc_acc;
   logic [31:0] cap_calc;
   logic [31:0] cap_rx;
   logic        cap_vld;
   logic        done_pipe [1:CRC_LATENCY-1];
   logic        bad_pipe  [1:CRC_LATENCY-1];

   assign vd_pkt = rx_vd_pkt_t'(frame.word);

   // Restart on the FAW, fold in every word up to the packet
   always_ff @(posedge clk_i) begin
      if (frame.faw_boundary) begin
         crc_acc <= CRC_INIT;
      end else if (frame.active && !frame.crc_boundary) begin
         crc_acc <= crc32_step(crc_acc, frame.word);
      end
   end

   // First stage captures both values at the packet word
   always_ff @(posedge clk_i) begin
      if (frame.crc_boundary) begin
         cap_calc <= crc_acc;
         cap_rx   <= vd_pkt.crc;
      end
   end

   // Done strobes travel with their compare result, flushed when disabled
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !frame.active) begin
         cap_vld <= 1'b0;
         for (int i = 1; i < CRC_LATENCY; i++) begin
            done_pipe[i] <= 1'b0;
         end
      end else begin
         cap_vld      <= frame.crc_boundary;
         done_pipe[1] <= cap_vld;
         for (int i = 2; i < CRC_LATENCY; i++) begin
            done_pipe[i] <= done_pipe[i-1];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      bad_pipe[1] <= (cap_calc != cap_rx);
      for (int i = 2; i < CRC_LATENCY; i++) begin
         bad_pipe[i] <= bad_pipe[i-1];
      end
   end

   assign crc_done_o = done_pipe[CRC_LATENCY-1];
   assign crc_bad_o  = bad_pipe[CRC_LATENCY-1];

endmodule

// ==== src/rx_ctrl.sv ====
// Receive control block: frame counter, enable FSM, FAW check,
// sticky error flags and remote receiver-ready flag
`timescale 1ns/1ns

module rx_ctrl import rx_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        enable_i,
   input  logic [63:0] tdata_i,
   rx_frame_if.framer  frame,
   input  logic        crc_done_i,
   input  logic        crc_bad_i,
   output logic        release_ok_o,
   output logic        faw_error_o,
   output logic        crc_error_o,
   output logic        remote_rx_rdy_o
);

   localparam int CNT_W = $clog2(FRAME_WORDS);

   logic [CNT_W-1:0] word_cnt;
   logic             faw_bnd;
   logic             crc_bnd;
   logic             faw_fail;
   logic             crc_fail;
   rx_faw_t          faw_word;
   rx_state_e        state;
   rx_state_e        state_next;

   // Counter sits at 0 while disabled, so the first enabled word is the FAW
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !enable_i) begin
         word_cnt <= '0;
      end else if (word_cnt == CNT_W'(FRAME_WORDS - 1)) begin
         word_cnt <= '0;
      end else begin
         word_cnt <= word_cnt + 1'b1;
      end
   end

   assign faw_bnd  = enable_i && (word_cnt == '0);
   assign crc_bnd  = enable_i && (word_cnt == CNT_W'(FRAME_WORDS - 1));
   assign faw_word = rx_faw_t'(tdata_i);

   // Input word goes straight through to the datapath
   assign frame.word         = tdata_i;
   assign frame.active       = enable_i;
   assign frame.faw_boundary = faw_bnd;
   assign frame.crc_boundary = crc_bnd;

   assign faw_fail = faw_bnd && !faw_ok(tdata_i);
   assign crc_fail = crc_done_i && crc_bad_i;

   always_comb begin
      state_next = state;
      unique case (state)
         OFF:     state_next = (faw_fail || crc_fail) ? FAULT : RUN;
         RUN:     if (faw_fail || crc_fail) state_next = FAULT;
         FAULT:   state_next = FAULT;
         default: state_next = OFF;
      endcase
      // Dropping enable always restarts from OFF
      if (!enable_i) begin
         state_next = OFF;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state <= OFF;
      end else begin
         state <= state_next;
      end
   end

   assign release_ok_o = (state == RUN);

   // Sticky flags, only cleared by dropping enable
   always_ff @(posedge clk_i) begin
      if (!rst_n_i || !enable_i) begin
         faw_error_o     <= 1'b0;
         crc_error_o     <= 1'b0;
         remote_rx_rdy_o <= 1'b0;
      end else begin
         if (faw_fail) begin
            faw_error_o <= 1'b1;
         end
         if (crc_fail) begin
            crc_error_o <= 1'b1;
         end
         // Remote ready only updates from a good FAW
         if (faw_bnd && !faw_fail) begin
            remote_rx_rdy_o <= faw_word.rx_rdy;
         end
      end
   end

endmodule

// ==== src/rx_frame_if.sv ====
// Frame interface from the control block to the datapath blocks.
// Carries the input word and its frame position strobes
`timescale 1ns/1ns

interface rx_frame_if;

   logic [63:0] word;
   logic        active;
   // Word 0 and word 7 of the current frame
   logic        faw_boundary;
   logic        crc_boundary;

   modport framer (
      output word,
      output active,
      output faw_boundary,
      output crc_boundary
   );

   modport sink (
      input word,
      input active,
      input faw_boundary,
      input crc_boundary
   );

endinterface

// ==== src/rx_pkg.sv ====
// Shared types, constants and helper functions for the serial-link
// receive datapath: frame layout, control states, CRC-32 and FAW check
package rx_pkg;

   // Frame layout
   localparam int FRAME_WORDS   = 8;
   localparam int PAYLOAD_WORDS = 6;

   // Fixed frame alignment pattern in the top 56 bits of word 0
   localparam logic [55:0] FAW_PATTERN = 56'hBC_F6_28_5A_A5_C3_3C;

   // CRC-32 parameters, MSB first, no reflection, no final inversion
   localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
   localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

   // Frame alignment word
   typedef struct packed {
      logic [55:0] pattern;
      logic [6:0]  rsvd;
      logic        rx_rdy;
   } rx_faw_t;

   // Validation packet, valids bit i belongs to payload word i+1
   typedef struct packed {
      logic [31:0]              crc;
      logic [25:0]              rsvd;
      logic [PAYLOAD_WORDS-1:0] valids;
   } rx_vd_pkt_t;

   // Control states
   typedef enum logic [1:0] {
      OFF,
      RUN,
      FAULT
   } rx_state_e;

   // Advance the CRC over one 64-bit word, bit 63 first
   function automatic logic [31:0] crc32_step(input logic [31:0] crc_in,
                                              input logic [63:0] data);
      logic [31:0] crc;
      logic        fb;
      crc = crc_in;
      for (int i = 63; i >= 0; i--) begin
         fb  = crc[31] ^ data[i];
         crc = {crc[30:0], 1'b0};
         if (fb) begin
            crc = crc ^ CRC_POLY;
         end
      end
      return crc;
   endfunction

   // True when the pattern field matches the alignment pattern
   function automatic logic faw_ok(input logic [63:0] word);
      rx_faw_t faw;
      faw = rx_faw_t'(word);
      return faw.pattern == FAW_PATTERN;
   endfunction

endpackage
